//--- source/arcade_pkg.sv
// Shared types, memory map and video timing for the arcade core shell
// Referenced by scoped name from every RTL block

package arcade_pkg;

    typedef logic [21:0] sdram_addr_t;  // SDRAM word address
    typedef logic [15:0] sdram_word_t;
    typedef logic [ 7:0] rom_byte_t;
    typedef logic [16:0] main_addr_t;   // Main CPU byte address
    typedef logic [14:0] snd_addr_t;    // Sound CPU byte address
    typedef logic [17:0] gfx_addr_t;    // Graphics word address
    typedef logic [ 8:0] hcount_t;
    typedef logic [ 8:0] vcount_t;
    typedef logic [21:0] loader_addr_t; // Byte address from the loader

    // Region bases in SDRAM words
    localparam sdram_addr_t main_offset = 22'h00000;
    localparam sdram_addr_t snd_offset  = 22'h10000;
    localparam sdram_addr_t gfx_offset  = 22'h14000;

    // Loader byte address of the game configuration byte, kept out of SDRAM
    localparam loader_addr_t cfg_byte_addr = 22'hA8000;

    // Horizontal timing in pixels
    localparam hcount_t h_total   = 9'd384;
    localparam hcount_t h_visible = 9'd256;
    localparam hcount_t hs_start  = 9'd296;
    localparam hcount_t hs_end    = 9'd328;

    // Vertical timing in lines
    localparam vcount_t v_total   = 9'd262;
    localparam vcount_t v_visible = 9'd224;
    localparam vcount_t vs_start  = 9'd232;
    localparam vcount_t vs_end    = 9'd236;

endpackage

//--- source/clock_enables.sv
// Clock-enable pulses for the 48 MHz system clock
// cen12, cen6 and cen3 are single-cycle strobes aligned to the same count

module clock_enables (
    input  logic clk,
    input  logic arst_n,
    output logic cen12,     // 12 MHz
    output logic cen6,      //  6 MHz
    output logic cen3       //  3 MHz
);

    logic [3:0] cnt;

    // Decoded at the last count of each period, so every cen3 lines up
    // with a cen6 and every cen6 with a cen12
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt   <= '0;
            cen12 <= 1'b0;
            cen6  <= 1'b0;
            cen3  <= 1'b0;
        end else begin
            cnt   <= cnt + 4'd1;        // Free running
            cen12 <= &cnt[1:0];
            cen6  <= &cnt[2:0];
            cen3  <= &cnt;
        end
    end

    // Slower enables must be a subset of the faster ones
    assert property (@(posedge clk) disable iff (!arst_n)
        cen3 |-> (cen6 && cen12))
    else $error("cen3 pulse without cen6");

    // cen6 repeats exactly every 8 cycles
    assert property (@(posedge clk) disable iff (!arst_n)
        cen6 |=> !cen6 [*7] ##1 cen6)
    else $error("cen6 period broken");

endmodule

//--- source/video_timer.sv
// Pixel and line counters for the 256x224 raster
// Advances on cen6; blanking and sync levels register together with h and v,
// so they always describe the current position

module video_timer (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                cen6,
    output arcade_pkg::hcount_t h,
    output arcade_pkg::vcount_t v,
    output logic                lhbl,   // High during visible pixels
    output logic                lvbl,   // High during visible lines
    output logic                hs,
    output logic                vs
);

    arcade_pkg::hcount_t h_next;
    arcade_pkg::vcount_t v_next;

    // Next position, v only moves when h wraps
    always_comb begin
        h_next = h + 9'd1;
        v_next = v;
        if (h == arcade_pkg::h_total - 9'd1) begin
            h_next = '0;
            if (v == arcade_pkg::v_total - 9'd1) begin
                v_next = '0;
            end else begin
                v_next = v + 9'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            h    <= '0;
            v    <= '0;
            lhbl <= 1'b1;   // Position 0,0 is visible
            lvbl <= 1'b1;
            hs   <= 1'b0;
            vs   <= 1'b0;
        end else if (cen6) begin
            h    <= h_next;
            v    <= v_next;
            lhbl <= h_next < arcade_pkg::h_visible;
            lvbl <= v_next < arcade_pkg::v_visible;
            hs   <= (h_next >= arcade_pkg::hs_start) && (h_next < arcade_pkg::hs_end);
            vs   <= (v_next >= arcade_pkg::vs_start) && (v_next < arcade_pkg::vs_end);
        end
    end

    // Counter must never leave the line
    assert property (@(posedge clk) disable iff (!arst_n)
        h < arcade_pkg::h_total)
    else $error("h beyond h_total");

    // Sync pulses only inside the blanking interval
    assert property (@(posedge clk) disable iff (!arst_n)
        (hs |-> !lhbl) and (vs |-> !lvbl))
    else $error("sync outside blanking");

endmodule

//--- source/rom_download.sv
// ROM download path from the loader byte stream to SDRAM
// Each byte becomes a masked 16-bit word write held until sdram_ack;
// the configuration byte is kept locally in game_cfg

module rom_download (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     downloading,
    input  logic                     ioctl_wr,
    input  logic                     sdram_ack,
    input  arcade_pkg::loader_addr_t ioctl_addr,
    input  arcade_pkg::rom_byte_t    ioctl_dout,
    output arcade_pkg::sdram_addr_t  prog_addr,
    output arcade_pkg::rom_byte_t    prog_data,
    output logic [1:0]               prog_mask,  // Active low byte enables
    output logic                     prog_we,
    output arcade_pkg::rom_byte_t    game_cfg
);

    logic is_cfg;

    assign is_cfg = ioctl_addr == arcade_pkg::cfg_byte_addr;

    // Write strobe and configuration register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prog_we  <= 1'b0;
            game_cfg <= '0;
        end else begin
            if (sdram_ack) begin
                prog_we <= 1'b0;    // Drops the cycle after the ack
            end
            if (ioctl_wr) begin
                if (is_cfg) begin
                    game_cfg <= ioctl_dout;
                end else begin
                    prog_we <= 1'b1;
                end
            end
        end
    end

    // Pending write payload
    always_ff @(posedge clk) begin
        if (ioctl_wr && !is_cfg) begin
            prog_addr <= ioctl_addr >> 1;
            prog_data <= ioctl_dout;
            // Even byte goes to the low half, odd to the high half
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
        end
    end

    // Loader waits for the previous write to be acknowledged
    assert property (@(posedge clk) disable iff (!arst_n)
        ioctl_wr |-> !prog_we)
    else $error("ioctl_wr while a write is pending");

    assert property (@(posedge clk) disable iff (!arst_n)
        (ioctl_wr || prog_we) |-> downloading)
    else $error("ROM write outside download");

endmodule

//--- source/rom_slot_arbiter.sv
// Shares one SDRAM read port between the main, sound and graphics ROM slots
// Each slot has a one-word cache; misses are fetched one at a time,
// graphics first, then main, then sound

module rom_slot_arbiter (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    downloading,
    input  logic                    main_cs,
    input  logic                    snd_cs,
    input  logic                    gfx_cs,
    input  logic                    sdram_ack,
    input  logic                    data_rdy,
    input  arcade_pkg::main_addr_t  main_addr,
    input  arcade_pkg::snd_addr_t   snd_addr,
    input  arcade_pkg::gfx_addr_t   gfx_addr,
    input  arcade_pkg::sdram_word_t data_read,
    output arcade_pkg::rom_byte_t   main_dout,
    output arcade_pkg::rom_byte_t   snd_dout,
    output arcade_pkg::sdram_word_t gfx_dout,
    output logic                    main_ok,
    output logic                    snd_ok,
    output logic                    gfx_ok,
    output logic                    sdram_req,
    output arcade_pkg::sdram_addr_t sdram_addr
);

    typedef enum logic [1:0] {
        idle,
        wait_ack,
        wait_data
    } fetch_state_t;

    fetch_state_t            state;
    // Slot vectors: bit 0 gfx, bit 1 main, bit 2 sound
    arcade_pkg::sdram_addr_t slot_addr  [3];
    arcade_pkg::sdram_addr_t cache_addr [3];
    arcade_pkg::sdram_word_t cache_data [3];
    arcade_pkg::sdram_addr_t pick_addr;
    logic [2:0]              cs_vec;
    logic [2:0]              cache_valid;
    logic [2:0]              hit;
    logic [2:0]              miss;
    logic [2:0]              pick;
    logic [2:0]              fetch_sel;  // Slot of the fetch in flight

    assign cs_vec = {snd_cs, main_cs, gfx_cs};

    // Byte slots share one word between two addresses
    assign slot_addr[0] = arcade_pkg::gfx_offset + arcade_pkg::sdram_addr_t'(gfx_addr);
    assign slot_addr[1] = arcade_pkg::main_offset + arcade_pkg::sdram_addr_t'(main_addr[16:1]);
    assign slot_addr[2] = arcade_pkg::snd_offset + arcade_pkg::sdram_addr_t'(snd_addr[14:1]);

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            hit[i] = cache_valid[i] && (cache_addr[i] == slot_addr[i]);
        end
    end

    assign miss = cs_vec & ~hit;
    assign pick = miss & (~miss + 3'd1);    // Lowest set bit, gfx first

    always_comb begin
        if (pick[0]) begin
            pick_addr = slot_addr[0];
        end else if (pick[1]) begin
            pick_addr = slot_addr[1];
        end else begin
            pick_addr = slot_addr[2];
        end
    end

    assign {snd_ok, main_ok, gfx_ok} = cs_vec & hit;

    assign gfx_dout  = cache_data[0];
    assign main_dout = main_addr[0] ? cache_data[1][15:8] : cache_data[1][7:0];
    assign snd_dout  = snd_addr[0]  ? cache_data[2][15:8] : cache_data[2][7:0];

    // Fetch FSM
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= idle;
            sdram_req   <= 1'b0;
            fetch_sel   <= '0;
            cache_valid <= '0;
        end else begin
            if (downloading) begin
                cache_valid <= '0;  // SDRAM contents are changing
            end else if (state == wait_data && data_rdy) begin
                cache_valid <= cache_valid | fetch_sel;
            end
            unique case (state)
                idle: begin
                    if (!downloading && |miss) begin
                        fetch_sel <= pick;
                        sdram_req <= 1'b1;
                        state     <= wait_ack;
                    end
                end
                wait_ack: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= wait_data;
                    end
                end
                wait_data: begin
                    if (data_rdy) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Address and cache payload
    always_ff @(posedge clk) begin
        if (state == idle) begin
            sdram_addr <= pick_addr;    // Frozen while the request is out
        end
        if (state == wait_data && data_rdy) begin
            for (int i = 0; i < 3; i++) begin
                if (fetch_sel[i]) begin
                    cache_addr[i] <= sdram_addr;
                    cache_data[i] <= data_read;
                end
            end
        end
    end

    // Download writes share sdram_ack
    assert property (@(posedge clk) disable iff (!arst_n || downloading)
        sdram_ack |-> sdram_req)
    else $error("sdram_ack without sdram_req");

endmodule

//--- source/arcade_core.sv
// Top level of the arcade core shell
// The testbench acts as the ROM clients and as the SDRAM controller

module arcade_core (
    input  logic                     clk,
    input  logic                     arst_n,
    // ROM download
    input  logic                     downloading,
    output logic                     dwnld_busy,
    input  logic                     ioctl_wr,
    input  arcade_pkg::loader_addr_t ioctl_addr,
    input  arcade_pkg::rom_byte_t    ioctl_dout,
    output arcade_pkg::sdram_addr_t  prog_addr,
    output arcade_pkg::rom_byte_t    prog_data,
    output logic [1:0]               prog_mask,
    output logic                     prog_we,
    output arcade_pkg::rom_byte_t    game_cfg,
    // ROM slots
    input  logic                     main_cs,
    input  arcade_pkg::main_addr_t   main_addr,
    output arcade_pkg::rom_byte_t    main_dout,
    output logic                     main_ok,
    input  logic                     snd_cs,
    input  arcade_pkg::snd_addr_t    snd_addr,
    output arcade_pkg::rom_byte_t    snd_dout,
    output logic                     snd_ok,
    input  logic                     gfx_cs,
    input  arcade_pkg::gfx_addr_t    gfx_addr,
    output arcade_pkg::sdram_word_t  gfx_dout,
    output logic                     gfx_ok,
    // SDRAM
    output logic                     sdram_req,
    output arcade_pkg::sdram_addr_t  sdram_addr,
    input  arcade_pkg::sdram_word_t  data_read,
    input  logic                     data_rdy,
    input  logic                     sdram_ack,  // Shared by writes and reads
    // Video
    output logic                     pxl2_cen,   // 12 MHz
    output logic                     pxl_cen,    //  6 MHz
    output logic                     lhbl,
    output logic                     lvbl,
    output logic                     hs,
    output logic                     vs
);

    arcade_pkg::hcount_t h;     // For the video blocks still to come
    arcade_pkg::vcount_t v;

    assign dwnld_busy = downloading;

    clock_enables u_cen (
        .clk    ( clk      ),
        .arst_n ( arst_n   ),
        .cen12  ( pxl2_cen ),
        .cen6   ( pxl_cen  ),
        .cen3   (          )    // CPU enable, no CPU here yet
    );

    video_timer u_timer (
        .clk    ( clk      ),
        .arst_n ( arst_n   ),
        .cen6   ( pxl_cen  ),
        .h      ( h        ),
        .v      ( v        ),
        .lhbl   ( lhbl     ),
        .lvbl   ( lvbl     ),
        .hs     ( hs       ),
        .vs     ( vs       )
    );

    rom_download u_download (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .ioctl_wr    ( ioctl_wr    ),
        .sdram_ack   ( sdram_ack   ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     ),
        .game_cfg    ( game_cfg    )
    );

    rom_slot_arbiter u_rom (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .main_cs     ( main_cs     ),
        .snd_cs      ( snd_cs      ),
        .gfx_cs      ( gfx_cs      ),
        .sdram_ack   ( sdram_ack   ),
        .data_rdy    ( data_rdy    ),
        .main_addr   ( main_addr   ),
        .snd_addr    ( snd_addr    ),
        .gfx_addr    ( gfx_addr    ),
        .data_read   ( data_read   ),
        .main_dout   ( main_dout   ),
        .snd_dout    ( snd_dout    ),
        .gfx_dout    ( gfx_dout    ),
        .main_ok     ( main_ok     ),
        .snd_ok      ( snd_ok      ),
        .gfx_ok      ( gfx_ok      ),
        .sdram_req   ( sdram_req   ),
        .sdram_addr  ( sdram_addr  )
    );

endmodule

//--- verification/arcade_tb_checks.svh
// Reference model, random source and typed compare tasks for the arcade core testbench
// Included inside arcade_core_tb; uses its image array and error count

`ifndef ARCADE_TB_CHECKS_SVH
`define ARCADE_TB_CHECKS_SVH

logic [31:0] lcg_state = 32'hd5a2b9ef;

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// Word the loader bytes should have built at one SDRAM word address
function automatic arcade_pkg::sdram_word_t expect_word(arcade_pkg::sdram_addr_t wa);
    return image.exists(wa) ? image[wa] : 16'h0000;
endfunction

// Byte seen by an 8-bit slot, even address in the low half
function automatic arcade_pkg::rom_byte_t expect_slot_byte(arcade_pkg::sdram_addr_t base,
                                                           int byte_addr);
    arcade_pkg::sdram_word_t w;
    w = expect_word(base + arcade_pkg::sdram_addr_t'(byte_addr >> 1));
    return byte_addr[0] ? w[15:8] : w[7:0];
endfunction

// Levels as {lhbl, lvbl, hs, vs}
function automatic logic [3:0] expect_levels(arcade_pkg::hcount_t h, arcade_pkg::vcount_t v);
    return {h < arcade_pkg::h_visible, v < arcade_pkg::v_visible,
            (h >= arcade_pkg::hs_start) && (h < arcade_pkg::hs_end),
            (v >= arcade_pkg::vs_start) && (v < arcade_pkg::vs_end)};
endfunction

task automatic check_byte(input string name, input arcade_pkg::rom_byte_t exp,
                          input arcade_pkg::rom_byte_t act);
    if (act !== exp) begin
        errors++;
        $display("FAILED %s: expected %h, got %h", name, exp, act);
    end
endtask

task automatic check_word(input string name, input arcade_pkg::sdram_word_t exp,
                          input arcade_pkg::sdram_word_t act);
    if (act !== exp) begin
        errors++;
        $display("FAILED %s: expected %h, got %h", name, exp, act);
    end
endtask

task automatic check_levels(input string name, input logic [3:0] exp, input logic [3:0] act);
    if (act !== exp) begin
        errors++;
        $display("FAILED %s: expected %b, got %b (lhbl lvbl hs vs)", name, exp, act);
    end
endtask

`endif

//--- verification/arcade_core_tb.sv
// Testbench for arcade_core, acting as loader, ROM clients and SDRAM controller
// Runs clock enable, download, slot read, cache, invalidation and video timing tests

module arcade_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int video_pulses    = 262 * 384 + 512;  // A full frame and a bit
    localparam int watchdog_cycles = 16 + 100 + 193 * 12 + 40 * 40 + 100 + video_pulses * 8
                                     + 5000;

    logic clk = 1'b0;
    logic arst_n;
    logic downloading, ioctl_wr, main_cs, snd_cs, gfx_cs, data_rdy, sdram_ack;
    logic dwnld_busy, prog_we, main_ok, snd_ok, gfx_ok, sdram_req;
    logic pxl2_cen, pxl_cen, lhbl, lvbl, hs, vs;
    logic [1:0] prog_mask;
    arcade_pkg::loader_addr_t ioctl_addr;
    arcade_pkg::rom_byte_t    ioctl_dout, prog_data, game_cfg, main_dout, snd_dout;
    arcade_pkg::sdram_addr_t  prog_addr, sdram_addr;
    arcade_pkg::sdram_word_t  data_read, gfx_dout;
    arcade_pkg::main_addr_t   main_addr;
    arcade_pkg::snd_addr_t    snd_addr;
    arcade_pkg::gfx_addr_t    gfx_addr;

    arcade_pkg::sdram_word_t mem   [arcade_pkg::sdram_addr_t];  // SDRAM model contents
    arcade_pkg::sdram_word_t image [arcade_pkg::sdram_addr_t];  // Expected contents
    arcade_pkg::sdram_addr_t fetch_log [$];                     // Read addresses in order
    arcade_pkg::hcount_t     hm = '0;                           // Predicted raster position
    arcade_pkg::vcount_t     vm = '0;
    int   errors     = 0;
    int   tests      = 0;
    int   cfg_writes = 0;
    int   req_count  = 0;
    int   req_in_dl  = 0;
    int   last_off [3];
    logic video_on   = 1'b0;
    logic req_q      = 1'b0;

    `include "arcade_tb_checks.svh"

    arcade_core u_arcade_core (.*);

    always #10 clk = ~clk;

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles", watchdog_cycles);
        $display("Simulation FAILED");
        $finish;
    end

    // SDRAM model, one write or read at a time
    initial begin : sdram_model
        arcade_pkg::sdram_addr_t rd_addr;
        arcade_pkg::sdram_word_t wd;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(negedge clk);
            if (prog_we) begin
                repeat (lcg_next() >> 30) @(negedge clk);
                wd = mem.exists(prog_addr) ? mem[prog_addr] : 16'h0000;
                if (!prog_mask[0]) wd[7:0] = prog_data;    // Mask is active low
                if (!prog_mask[1]) wd[15:8] = prog_data;
                mem[prog_addr] = wd;
                if (prog_addr == (arcade_pkg::cfg_byte_addr >> 1)) cfg_writes++;
                sdram_ack = 1'b1;
                @(negedge clk);
                sdram_ack = 1'b0;
            end else if (sdram_req) begin
                rd_addr = sdram_addr;
                fetch_log.push_back(rd_addr);
                repeat (lcg_next() >> 30) @(negedge clk);
                sdram_ack = 1'b1;
                @(negedge clk);
                sdram_ack = 1'b0;
                repeat (lcg_next() >> 30) @(negedge clk);
                data_read = mem.exists(rd_addr) ? mem[rd_addr] : 16'h0000;
                data_rdy  = 1'b1;
                @(negedge clk);
                data_rdy  = 1'b0;
            end
        end
    end

    // Request monitor and raster tracker
    always @(negedge clk) begin
        if (sdram_req && !req_q) req_count++;
        if (sdram_req && downloading) req_in_dl++;
        req_q = sdram_req;
        if (arst_n && pxl_cen) begin
            if (video_on) begin
                check_levels($sformatf("video at h=%0d v=%0d", hm, vm), expect_levels(hm, vm),
                             {lhbl, lvbl, hs, vs});
            end
            if (hm == arcade_pkg::h_total - 9'd1) begin
                hm = '0;
                vm = (vm == arcade_pkg::v_total - 9'd1) ? '0 : vm + 9'd1;
            end else begin
                hm = hm + 9'd1;
            end
        end
    end

    task automatic report_test(input string name, input int start_errors);
        tests++;
        $display("test %-14s %0d errors", name, errors - start_errors);
    endtask

    task automatic check_cen(input string name, input int period);
        int n;
        for (int k = 0; k < 5; k++) begin
            n = 0;
            do begin
                @(negedge clk);
                n++;
            end while (!(period == 4 ? pxl2_cen : pxl_cen) && n < 64);
            if (k > 0 && n != period) begin     // First pass only finds a pulse
                errors++;
                $display("FAILED %s period: expected %0d, got %0d", name, period, n);
            end
        end
    endtask

    task automatic check_busy(input string name, input logic exp);
        if (dwnld_busy !== exp) begin
            errors++;
            $display("FAILED %s: expected %b, got %b", name, exp, dwnld_busy);
        end
    endtask

    task automatic write_loader(input arcade_pkg::loader_addr_t a, input arcade_pkg::rom_byte_t d);
        int n;
        @(negedge clk);
        ioctl_wr   = 1'b1;
        ioctl_addr = a;
        ioctl_dout = d;
        @(negedge clk);
        ioctl_wr   = 1'b0;
        n = 0;
        while (prog_we && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (prog_we) begin
            errors++;
            $display("ERROR: write to loader address %h was never acknowledged", a);
        end
    endtask

    task automatic download_window(input arcade_pkg::loader_addr_t base);
        arcade_pkg::loader_addr_t a;
        arcade_pkg::rom_byte_t    d;
        arcade_pkg::sdram_word_t  w;
        for (int i = 0; i < 64; i++) begin
            a = base + i;
            d = arcade_pkg::rom_byte_t'(lcg_next() >> 24);
            w = expect_word(a >> 1);
            if (a[0]) w[15:8] = d;
            else w[7:0] = d;
            image[a >> 1] = w;
            write_loader(a, d);
        end
    endtask

    // Windows: main bytes 0x400, sound bytes 0x200, gfx words 0x400
    task automatic drive_slot(input int slot, input int off, input logic cs);
        case (slot)
            0: begin
                gfx_cs   = cs;
                gfx_addr = 18'h00400 + off;
            end
            1: begin
                main_cs   = cs;
                main_addr = 17'h00400 + off;
            end
            default: begin
                snd_cs   = cs;
                snd_addr = 15'h0200 + off;
            end
        endcase
    endtask

    task automatic check_slot(input int slot, input int off);
        if (slot == 0) begin
            check_word("gfx read", expect_word(arcade_pkg::gfx_offset + 22'h400 + off), gfx_dout);
        end else if (slot == 1) begin
            check_byte("main read", expect_slot_byte(arcade_pkg::main_offset, 'h400 + off),
                       main_dout);
        end else begin
            check_byte("sound read", expect_slot_byte(arcade_pkg::snd_offset, 'h200 + off),
                       snd_dout);
        end
    endtask

    task automatic wait_ok(input logic [2:0] want);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (({snd_ok, main_ok, gfx_ok} & want) != want && n < 200);
        if (({snd_ok, main_ok, gfx_ok} & want) != want) begin
            errors++;
            $display("ERROR: ok never rose for slots %b (sound main gfx)", want);
        end
    endtask

    initial begin : stimulus
        int start;
        int n;
        int slot;
        arcade_pkg::rom_byte_t cfg;
        arst_n      = 1'b0;
        downloading = 1'b0;
        ioctl_wr    = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        main_cs     = 1'b0;
        snd_cs      = 1'b0;
        gfx_cs      = 1'b0;
        main_addr   = '0;
        snd_addr    = '0;
        gfx_addr    = '0;
        repeat (16) @(negedge clk);
        arst_n = 1'b1;

        start = errors;
        check_cen("pxl2_cen", 4);
        check_cen("pxl_cen", 8);
        report_test("clock enables", start);

        start = errors;
        @(negedge clk);
        downloading = 1'b1;
        download_window(22'h00400);
        download_window(22'h20200);
        download_window(22'h28800);
        cfg = arcade_pkg::rom_byte_t'(lcg_next() >> 24);
        write_loader(arcade_pkg::cfg_byte_addr, cfg);
        check_byte("game_cfg", cfg, game_cfg);
        check_busy("dwnld_busy in download", 1'b1);
        if (cfg_writes != 0) begin
            errors++;
            $display("ERROR: configuration byte was written to SDRAM");
        end
        foreach (image[a]) check_word("sdram image", image[a], mem.exists(a) ? mem[a] : 'x);
        downloading = 1'b0;
        report_test("download", start);

        start = errors;
        for (int k = 0; k < 30; k++) begin
            slot = k % 3;
            last_off[slot] = (lcg_next() >> 26) % (slot == 0 ? 32 : 64);
            @(negedge clk);
            drive_slot(slot, last_off[slot], 1'b1);
            wait_ok(3'b001 << slot);
            check_slot(slot, last_off[slot]);
            drive_slot(slot, last_off[slot], 1'b0);
        end
        check_busy("dwnld_busy after download", 1'b0);
        report_test("slot reads", start);

        // All three miss together, gfx must be fetched first
        start = errors;
        @(negedge clk);
        n = fetch_log.size();
        for (int s = 0; s < 3; s++) begin
            last_off[s] = (last_off[s] + 2) % (s == 0 ? 32 : 64);
            drive_slot(s, last_off[s], 1'b1);
        end
        wait_ok(3'b111);
        for (int s = 0; s < 3; s++) check_slot(s, last_off[s]);
        if (fetch_log.size() != n + 3 ||
            fetch_log[n] != arcade_pkg::gfx_offset + 22'h400 + last_off[0]) begin
            errors++;
            $display("ERROR: fetches were not three with the gfx slot first");
        end
        n = req_count;
        repeat (20) @(negedge clk);
        if (req_count != n) begin
            errors++;
            $display("ERROR: sdram_req rose while every slot held a cached address");
        end
        report_test("cache priority", start);

        start = errors;
        downloading = 1'b1;
        @(negedge clk);
        if ({snd_ok, main_ok, gfx_ok} != 3'b000) begin
            errors++;
            $display("ERROR: ok stayed high after downloading rose");
        end
        repeat (20) @(negedge clk);
        if (req_in_dl != 0) begin
            errors++;
            $display("ERROR: sdram_req seen %0d times while downloading", req_in_dl);
        end
        downloading = 1'b0;
        for (int s = 0; s < 3; s++) drive_slot(s, last_off[s], 1'b0);
        report_test("invalidation", start);

        start = errors;
        @(posedge clk);
        video_on = 1'b1;
        repeat (video_pulses) begin
            @(negedge clk);
            while (!pxl_cen) @(negedge clk);
        end
        @(posedge clk);
        video_on = 1'b0;
        report_test("video timing", start);

        $display("Finished %0d tests with %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+verification
source/arcade_pkg.sv
source/clock_enables.sv
source/video_timer.sv
source/rom_download.sv
source/rom_slot_arbiter.sv
source/arcade_core.sv
verification/arcade_core_tb.sv

//--- Bender.yml
package:
  name: arcade_core

sources:
  - files:
      - source/arcade_pkg.sv
      - source/clock_enables.sv
      - source/video_timer.sv
      - source/rom_download.sv
      - source/rom_slot_arbiter.sv
      - source/arcade_core.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/arcade_core_tb.sv
